// ==== build.f ====
src/lc3b_pkg.sv
src/cache_control.sv
src/cache_datapath.sv
src/cache.sv
src/arbiter.sv
src/mem_hierarchy.sv
verification/mem_hierarchy_asserts.sv
verification/mem_hierarchy_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --assert -f build.f --top-module mem_hierarchy_tb -o mem_hierarchy_sim \
	&& ./obj_dir/mem_hierarchy_sim > sim.log 2>&1 \
	|| echo "RESULT: FAIL" >> sim.log
cat sim.log
! grep -q "RESULT: FAIL" sim.log

// ==== src/arbiter.sv ====
module arbiter (
	input logic clk,
	input logic rst_n,

	input lc3b_pkg::lc3b_pmem_req icache_pmem_req,
	input lc3b_pkg::lc3b_pmem_req dcache_pmem_req,

	input logic pmem_resp,

	output lc3b_pkg::lc3b_pmem_req pmem_req,
	output logic icache_pmem_resp,
	output logic dcache_pmem_resp
);

	typedef enum logic [1:0] {
		arb_idle,
		arb_icache,
		arb_dcache
	} grant_t;

	grant_t grant;
	logic icache_wants;
	logic dcache_wants;

	assign icache_wants = icache_pmem_req.read | icache_pmem_req.write;
	assign dcache_wants = dcache_pmem_req.read | dcache_pmem_req.write;

	// data cache wins when both ask
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant <= arb_idle;
		end else begin
			case (grant)
				arb_idle: begin
					if (dcache_wants) begin
						grant <= arb_dcache;
					end else if (icache_wants) begin
						grant <= arb_icache;
					end
				end
				default: begin
					if (pmem_resp) begin
						grant <= arb_idle;
					end
				end
			endcase
		end
	end

	always_comb begin
		case (grant)
			arb_icache: pmem_req = icache_pmem_req;
			arb_dcache: pmem_req = dcache_pmem_req;
			default: pmem_req = '0;
		endcase
	end

	assign icache_pmem_resp = pmem_resp && (grant == arb_icache);
	assign dcache_pmem_resp = pmem_resp && (grant == arb_dcache);

endmodule : arbiter

// ==== src/cache.sv ====
module cache #(
	parameter bit writable = 1'b1
) (
	input logic clk,
	input logic rst_n,

	// cpu side
	input lc3b_pkg::lc3b_mem_req req,
	output lc3b_pkg::lc3b_word mem_rdata,
	output logic mem_resp,

	// physical memory side
	output lc3b_pkg::lc3b_pmem_req pmem_req,
	input lc3b_pkg::lc3b_c_block pmem_rdata,
	input logic pmem_resp
);

	logic hit;
	logic dirty;
	logic load_line;
	logic load_word;
	logic addr_sel_old_tag;

	cache_control control (
		.clk,
		.rst_n,
		.mem_read(req.read),
		// a read-only cache never takes a write
		.mem_write(writable && req.write),
		.hit,
		.dirty,
		.pmem_resp,
		.mem_resp,
		.pmem_read(pmem_req.read),
		.pmem_write(pmem_req.write),
		.load_line,
		.load_word,
		.addr_sel_old_tag
	);

	cache_datapath #(
		.writable(writable)
	) datapath (
		.clk,
		.rst_n,
		.req,
		.load_line,
		.load_word,
		.addr_sel_old_tag,
		.pmem_rdata,
		.hit,
		.dirty,
		.mem_rdata,
		.pmem_address(pmem_req.address),
		.pmem_wdata(pmem_req.wdata)
	);

endmodule : cache

// ==== src/cache_control.sv ====
module cache_control (
	input logic clk,
	input logic rst_n,

	input logic mem_read,
	input logic mem_write,

	input logic hit,
	input logic dirty,

	input logic pmem_resp,

	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,

	output logic load_line,
	output logic load_word,
	output logic addr_sel_old_tag
);

	typedef enum logic [1:0] {
		s_compare,
		s_write_back,
		s_fill
	} state_t;

	state_t state;
	state_t next_state;
	logic request;

	// the request is still held during its resp cycle, do not count it twice
	assign request = (mem_read | mem_write) & ~mem_resp;

	always_comb begin
		next_state = state;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		load_line = 1'b0;
		load_word = 1'b0;
		addr_sel_old_tag = 1'b0;

		case (state)
			s_compare: begin
				if (request && hit) begin
					load_word = mem_write;
				end else if (request) begin
					next_state = dirty ? s_write_back : s_fill;
				end
			end
			s_write_back: begin
				// victim line goes out under its old tag
				pmem_write = 1'b1;
				addr_sel_old_tag = 1'b1;
				if (pmem_resp) begin
					next_state = s_fill;
				end
			end
			s_fill: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					load_line = 1'b1;
					next_state = s_compare;
				end
			end
			default: next_state = s_compare;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_compare;
			mem_resp <= 1'b0;
		end else begin
			state <= next_state;
			// hit answered one cycle later
			mem_resp <= (state == s_compare) && request && hit;
		end
	end

endmodule : cache_control

// ==== src/cache_datapath.sv ====
module cache_datapath #(
	parameter bit writable = 1'b1
) (
	input logic clk,
	input logic rst_n,

	input lc3b_pkg::lc3b_mem_req req,

	input logic load_line,
	input logic load_word,
	input logic addr_sel_old_tag,

	input lc3b_pkg::lc3b_c_block pmem_rdata,

	output logic hit,
	output logic dirty,
	output lc3b_pkg::lc3b_word mem_rdata,
	output lc3b_pkg::lc3b_word pmem_address,
	output lc3b_pkg::lc3b_c_block pmem_wdata
);

	lc3b_pkg::lc3b_cache_addr addr;
	lc3b_pkg::lc3b_cache_addr line_addr;

	logic [lc3b_pkg::tag_bits-1:0] tag_array [lc3b_pkg::num_lines];
	lc3b_pkg::lc3b_c_block data_array [lc3b_pkg::num_lines];
	logic [lc3b_pkg::num_lines-1:0] valid_bits;

	logic [lc3b_pkg::index_bits-1:0] index;
	logic [lc3b_pkg::offset_bits-2:0] word_sel;
	lc3b_pkg::lc3b_c_block line;

	logic line_we;
	lc3b_pkg::lc3b_c_block line_wdata;

	assign addr.word = req.address;
	assign index = addr.fields.index;
	assign word_sel = addr.fields.offset[lc3b_pkg::offset_bits-1:1];
	assign line = data_array[index];

	assign hit = valid_bits[index] && (tag_array[index] == addr.fields.tag);
	assign mem_rdata = line[word_sel*lc3b_pkg::word_bits +: lc3b_pkg::word_bits];

	// line aligned address, old tag during write-back
	always_comb begin
		line_addr.fields.tag = addr_sel_old_tag ? tag_array[index] : addr.fields.tag;
		line_addr.fields.index = index;
		line_addr.fields.offset = '0;
	end

	assign pmem_address = line_addr.word;
	assign pmem_wdata = line;

	generate
		if (writable) begin : g_write
			logic [lc3b_pkg::num_lines-1:0] dirty_bits;
			lc3b_pkg::lc3b_word merged_word;
			lc3b_pkg::lc3b_c_block merged_line;

			// byte merge of the cpu write into the current line
			always_comb begin
				merged_word[15:8] = req.byte_enable[1] ? req.wdata[15:8] : mem_rdata[15:8];
				merged_word[7:0] = req.byte_enable[0] ? req.wdata[7:0] : mem_rdata[7:0];
				merged_line = line;
				merged_line[word_sel*lc3b_pkg::word_bits +: lc3b_pkg::word_bits] = merged_word;
			end

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					dirty_bits <= '0;
				end else if (load_line) begin
					dirty_bits[index] <= 1'b0;
				end else if (load_word) begin
					dirty_bits[index] <= 1'b1;
				end
			end

			assign dirty = valid_bits[index] & dirty_bits[index];
			assign line_we = load_line | load_word;
			assign line_wdata = load_line ? pmem_rdata : merged_line;
		end else begin : g_read_only
			assign dirty = 1'b0;
			assign line_we = load_line;
			assign line_wdata = pmem_rdata;
		end
	endgenerate

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
		end else if (load_line) begin
			valid_bits[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_line) begin
			tag_array[index] <= addr.fields.tag;
		end
		if (line_we) begin
			data_array[index] <= line_wdata;
		end
	end

endmodule : cache_datapath

// ==== src/lc3b_pkg.sv ====
package lc3b_pkg;

	// data and address width
	localparam int word_bits = 16;

	// cache geometry, 16-byte lines, 8 lines
	localparam int offset_bits = 4;
	localparam int index_bits = 3;
	localparam int tag_bits = 9;
	localparam int num_lines = 8;

	typedef logic [word_bits-1:0] lc3b_word;

	// one cache line, eight words
	typedef logic [127:0] lc3b_c_block;

	// bit 0 enables the low byte
	typedef logic [1:0] lc3b_mem_wmask;

	typedef struct packed {
		logic [tag_bits-1:0] tag;
		logic [index_bits-1:0] index;
		logic [offset_bits-1:0] offset;
	} lc3b_cache_fields;

	// same 16 bits, seen as a word or as tag/index/offset
	typedef union packed {
		lc3b_word word;
		lc3b_cache_fields fields;
	} lc3b_cache_addr;

	// cpu side request into a cache
	typedef struct packed {
		lc3b_word address;
		logic read;
		logic write;
		lc3b_mem_wmask byte_enable;
		lc3b_word wdata;
	} lc3b_mem_req;

	// line request towards physical memory
	typedef struct packed {
		lc3b_word address;
		logic read;
		logic write;
		lc3b_c_block wdata;
	} lc3b_pmem_req;

endpackage : lc3b_pkg

// ==== src/mem_hierarchy.sv ====
module mem_hierarchy (
	input logic clk,
	input logic rst_n,

	input lc3b_pkg::lc3b_mem_req icache_req,
	input lc3b_pkg::lc3b_mem_req dcache_req,

	output lc3b_pkg::lc3b_word icache_rdata,
	output lc3b_pkg::lc3b_word dcache_rdata,
	output logic icache_resp,
	output logic dcache_resp,

	output lc3b_pkg::lc3b_pmem_req pmem_req,
	input lc3b_pkg::lc3b_c_block pmem_rdata,
	input logic pmem_resp
);

	lc3b_pkg::lc3b_pmem_req icache_pmem_req;
	lc3b_pkg::lc3b_pmem_req dcache_pmem_req;
	logic icache_pmem_resp;
	logic dcache_pmem_resp;

	// instruction side, no write path
	cache #(
		.writable(1'b0)
	) i_cache (
		.clk,
		.rst_n,
		.req(icache_req),
		.mem_rdata(icache_rdata),
		.mem_resp(icache_resp),
		.pmem_req(icache_pmem_req),
		.pmem_rdata,
		.pmem_resp(icache_pmem_resp)
	);

	cache #(
		.writable(1'b1)
	) d_cache (
		.clk,
		.rst_n,
		.req(dcache_req),
		.mem_rdata(dcache_rdata),
		.mem_resp(dcache_resp),
		.pmem_req(dcache_pmem_req),
		.pmem_rdata,
		.pmem_resp(dcache_pmem_resp)
	);

	arbiter arbiter (
		.clk,
		.rst_n,
		.icache_pmem_req,
		.dcache_pmem_req,
		.pmem_resp,
		.pmem_req,
		.icache_pmem_resp,
		.dcache_pmem_resp
	);

endmodule : mem_hierarchy

// ==== verification/mem_hierarchy_asserts.sv ====
module mem_hierarchy_asserts (
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_mem_req icache_req,
	input lc3b_pkg::lc3b_mem_req dcache_req,
	input logic icache_resp,
	input logic dcache_resp,
	input lc3b_pkg::lc3b_pmem_req pmem_req,
	input logic pmem_resp,
	input logic icache_pmem_resp,
	input logic dcache_pmem_resp
);

	int unsigned fail_count = 0;

	assert property (@(posedge clk) disable iff (!rst_n) !(pmem_req.read && pmem_req.write))
		else begin
			$error("pmem read and pmem write raised together");
			fail_count++;
		end

	// line request held by the arbiter until memory answers
	assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_req.read || pmem_req.write) && !pmem_resp |=> $stable(pmem_req))
		else begin
			$error("pmem request changed before pmem_resp");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		(!icache_resp || icache_req.read)
		&& (!dcache_resp || dcache_req.read || dcache_req.write))
		else begin
			$error("cache response without a request");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n) !(icache_pmem_resp && dcache_pmem_resp))
		else begin
			$error("pmem response forwarded to both caches");
			fail_count++;
		end

	// first cycle out of reset is quiet
	assert property (@(posedge clk) $rose(rst_n) |-> !(pmem_req.read || pmem_req.write
		|| icache_resp || dcache_resp || icache_pmem_resp || dcache_pmem_resp))
		else begin
			$error("activity in the first cycle after reset");
			fail_count++;
		end

endmodule : mem_hierarchy_asserts

bind mem_hierarchy mem_hierarchy_asserts u_asserts (.*);

// ==== verification/mem_hierarchy_tb.sv ====
module mem_hierarchy_tb;

	logic clk;
	logic rst_n;
	lc3b_pkg::lc3b_mem_req icache_req;
	lc3b_pkg::lc3b_mem_req dcache_req;
	lc3b_pkg::lc3b_word icache_rdata;
	lc3b_pkg::lc3b_word dcache_rdata;
	logic icache_resp;
	logic dcache_resp;
	lc3b_pkg::lc3b_pmem_req pmem_req;
	lc3b_pkg::lc3b_c_block pmem_rdata;
	logic pmem_resp;

	lc3b_pkg::lc3b_word phys [32768];
	lc3b_pkg::lc3b_word shadow [32768];
	bit dirtied [4096];
	logic [16:0] pmem_log [$];
	int errors;
	int tests;
	int passed;
	int mark;

	mem_hierarchy i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// physical memory, whole lines, answered 4 cycles after a request is seen
	initial begin
		logic [14:0] widx;
		lc3b_pkg::lc3b_c_block line;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		for (int i = 0; i < 32768; i++) begin
			widx = 15'(i);
			phys[widx] = {widx, 1'b0} ^ 16'h5a5a;
		end
		forever begin
			@(negedge clk);
			pmem_resp = 1'b0;
			if (rst_n && (pmem_req.read || pmem_req.write)) begin
				pmem_log.push_back({pmem_req.write, pmem_req.address});
				repeat (4) @(negedge clk);
				widx = pmem_req.address[15:1];
				line = pmem_req.wdata;
				for (int w = 0; w < 8; w++) begin
					if (pmem_req.write) begin
						phys[widx] = line[15:0];
						line = line >> 16;
					end else begin
						line = {phys[widx], line[127:16]};
					end
					widx = widx + 15'd1;
				end
				if (!pmem_req.write) begin
					pmem_rdata = line;
				end
				pmem_resp = 1'b1;
			end
		end
	end

	function automatic bit logged(input logic [16:0] entry);
		foreach (pmem_log[k]) begin
			if (pmem_log[k] == entry) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// one request on either cache, held until its resp, checked against the shadow
	task automatic access(input bit instr, input lc3b_pkg::lc3b_word addr, input logic wr,
			input lc3b_pkg::lc3b_mem_wmask be, input lc3b_pkg::lc3b_word wd, output int cycles);
		lc3b_pkg::lc3b_mem_req req;
		lc3b_pkg::lc3b_word rdata;
		logic resp;
		logic [14:0] widx;
		string who;
		req.address = addr;
		req.read = ~wr;
		req.write = wr;
		req.byte_enable = be;
		req.wdata = wd;
		widx = addr[15:1];
		who = instr ? "icache read" : (wr ? "dcache write" : "dcache read");
		cycles = 0;
		@(negedge clk);
		if (instr) begin
			icache_req = req;
		end else begin
			dcache_req = req;
		end
		do begin
			@(negedge clk);
			cycles++;
			resp = instr ? icache_resp : dcache_resp;
			rdata = instr ? icache_rdata : dcache_rdata;
		end while (!resp && cycles < 200);
		if (!resp) begin
			$display("%s of address %h never answered within 200 cycles", who, addr);
			errors++;
		end else if (wr) begin
			if (be[0]) begin
				shadow[widx][7:0] = wd[7:0];
			end
			if (be[1]) begin
				shadow[widx][15:8] = wd[15:8];
			end
			dirtied[addr[15:4]] = 1'b1;
		end else begin
			assert (rdata === shadow[widx]) else begin
				$display("** Error at time %0t: %s of %h returned %h, expected %h",
					$time, who, addr, rdata, shadow[widx]);
				errors++;
			end
		end
		@(negedge clk);
		if (instr) begin
			icache_req = '0;
		end else begin
			dcache_req = '0;
		end
	endtask

	task automatic close_test(input string name);
		tests++;
		if (errors == mark) begin
			passed++;
			$display("test %0d, %s: ok", tests, name);
		end else begin
			$display("test %0d, %s: failed with %0d errors", tests, name, errors - mark);
		end
		mark = errors;
	endtask

	initial begin
		int cycles;
		int cycles2;
		logic [31:0] r;
		lc3b_pkg::lc3b_word addr;
		integer seed;
		logic [14:0] widx;
		seed = 32'hdb1d;
		errors = 0;
		tests = 0;
		passed = 0;
		mark = 0;
		icache_req = '0;
		dcache_req = '0;
		rst_n = 1'b0;
		for (int i = 0; i < 32768; i++) begin
			widx = 15'(i);
			shadow[widx] = {widx, 1'b0} ^ 16'h5a5a;
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		access(1'b1, 16'h1230, 1'b0, 2'b00, 16'h0000, cycles);
		access(1'b1, 16'h1236, 1'b0, 2'b00, 16'h0000, cycles);
		assert (cycles == 1) else begin
			$display("** Error at time %0t: warm icache read took %0d cycles, expected 1",
				$time, cycles);
			errors++;
		end
		close_test("cold and warm instruction read");

		access(1'b0, 16'h2000, 1'b1, 2'b01, 16'hc3a5, cycles);
		access(1'b0, 16'h2000, 1'b0, 2'b00, 16'h0000, cycles);
		access(1'b0, 16'h2000, 1'b1, 2'b10, 16'h7e81, cycles);
		access(1'b0, 16'h2000, 1'b0, 2'b00, 16'h0000, cycles);
		access(1'b0, 16'h2000, 1'b1, 2'b11, 16'h1bd4, cycles);
		access(1'b0, 16'h2000, 1'b0, 2'b00, 16'h0000, cycles);
		close_test("byte enabled writes");

		// same index, other tag evicts the dirty line
		pmem_log.delete();
		access(1'b0, 16'h2080, 1'b0, 2'b00, 16'h0000, cycles);
		if (!logged({1'b1, 16'h2000})) begin
			$display("no write-back of line 2000 reached physical memory");
			errors++;
		end
		access(1'b0, 16'h2000, 1'b0, 2'b00, 16'h0000, cycles);
		close_test("dirty write-back");

		pmem_log.delete();
		fork
			access(1'b1, 16'h3010, 1'b0, 2'b00, 16'h0000, cycles);
			access(1'b0, 16'h3100, 1'b0, 2'b00, 16'h0000, cycles2);
		join
		if (pmem_log.size() == 0) begin
			$display("no pmem request was seen during the joint miss");
			errors++;
		end else begin
			assert (pmem_log[0][15:0] == 16'h3100) else begin
				$display("** Error at time %0t: first pmem request went to %h, expected 3100",
					$time, pmem_log[0][15:0]);
				errors++;
			end
		end
		close_test("joint instruction and data miss");

		// 32 lines from 8000, four tags per index
		for (int k = 0; k < 300; k++) begin
			r = $random(seed);
			addr = {7'b1000000, r[8:1], 1'b0};
			case (r[10:9])
				2'd0: begin
					if (dirtied[addr[15:4]]) begin
						access(1'b0, addr, 1'b0, 2'b00, 16'h0000, cycles);
					end else begin
						access(1'b1, addr, 1'b0, 2'b00, 16'h0000, cycles);
					end
				end
				2'd1: access(1'b0, addr, 1'b0, 2'b00, 16'h0000, cycles);
				default: access(1'b0, addr, 1'b1, r[12:11], r[31:16], cycles);
			endcase
		end
		close_test("random traffic");

		$display("%0d of %0d tests passed, %0d check errors, %0d assertion failures",
			passed, tests, errors, i_dut.u_asserts.fail_count);
		if (errors == 0 && i_dut.u_asserts.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule : mem_hierarchy_tb
